//--- verif/zxuno_io_patterns.txt
# op port data kbdjoy db9joy kbdcol expected, all fields hex
# W write, R read dout, N read with oe_n high, K compare kbdcol_out
R FC3B 00 00 00 1F 00
N 001F 00 00 00 1F 00
N 007F 00 00 00 1F 00
W FC3B 06 00 00 1F 00
R FC3B 00 00 00 1F 06
W FC3B FF 00 00 1F 00
R FC3B 00 00 00 1F FF
W FC3B 42 00 00 1F 00
R FC3B 00 00 00 1F 42
N FD3B 00 00 00 1F 00
N 00FE 00 00 00 1F 00
W FC3B FF 00 00 1F 00
R FD3B 00 00 00 1F 5A
R FD3B 00 00 00 1F 58
R FD3B 00 00 00 1F 49
R FD3B 00 00 00 1F 4F
R FD3B 00 00 00 1F 32
R FD3B 00 00 00 1F 30
R FD3B 00 00 00 1F 32
R FD3B 00 00 00 1F 35
R FD3B 00 00 00 1F 00
R FD3B 00 00 00 1F 00
W FC3B FF 00 00 1F 00
R FD3B 00 00 00 1F 5A
R FD3B 00 00 00 1F 58
W FC3B 06 00 00 1F 00
W FD3B 51 00 00 1F 00
R FD3B 00 00 00 1F 51
R 001F 00 15 0A 1F 15
R 007F 00 15 0A 1F FA
W FD3B 11 00 00 1F 00
R FD3B 00 00 00 1F 11
R 001F 00 11 06 1F 17
N 007F 00 11 06 1F 00
W FD3B 55 00 00 1F 00
R 007F 00 10 01 1F 77
N 001F 00 10 01 1F 00
W FD3B 02 00 00 1F 00
K EFFE 00 15 00 1F 12
K FFFE 00 15 00 1F 1F
K F7FE 00 15 00 1F 1F
K EFFE 00 0A 00 1E 0C
W FD3B 30 00 00 1F 00
K F7FE 00 1F 15 1F 09
K EFFE 00 1F 15 1F 1F
K F7FE 00 00 0A 1F 16
W FD3B 04 00 00 1F 00
K F7FE 00 02 00 1F 0F
K EFFE 00 02 00 1F 1F
K EFFE 00 1D 00 1F 02
K FFFE 00 1F 00 1F 1F
K E7FE 00 1F 00 1F 02
K F7FE 00 1D 00 1F 1F
N 001F 00 1F 00 1F 00

//--- zxuno_io.f
verilog/zxuno_pkg.sv
verilog/zxuno_reg_if.sv
verilog/zxuno_regs.sv
verilog/core_id.sv
verilog/joystick_protocols.sv
verilog/zxuno_io.sv
verif/zxuno_io_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the zxuno_io testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary -j 0 --top-module zxuno_io_tb -f zxuno_io.f \
   --Mdir obj_dir -o zxuno_io_sim

./obj_dir/zxuno_io_sim | tee sim.log

if grep -q "ERRORS FOUND" sim.log; then
   echo "Simulation failed, see sim.log"
   exit 1
fi

echo "Simulation passed"

//--- verif/zxuno_io_tb.sv
`timescale 1ns/1ps
`default_nettype none

module zxuno_io_tb;

   // Clock and reset
   logic        clk;
   logic        rst;
   // Z80 style I/O bus
   logic [15:0] a;
   logic        iorq_n;
   logic        rd_n;
   logic        wr_n;
   logic [7:0]  din;
   logic [7:0]  dout;
   logic        oe_n;
   // Joysticks and keyboard columns
   logic [4:0]  kbdjoy_in;
   logic [4:0]  db9joy_in;
   logic [4:0]  kbdcol_in;
   logic [4:0]  kbdcol_out;

   int checks;
   int check_errs;
   int other_errs;

   // Clocks allowed for oe_n to go back high
   localparam int release_timeout = 8;
   // Upper bound on pattern file lines
   localparam int max_lines = 1000;

   zxuno_io dut0 (
      .clk        (clk),
      .rst        (rst),
      .a          (a),
      .iorq_n     (iorq_n),
      .rd_n       (rd_n),
      .wr_n       (wr_n),
      .din        (din),
      .dout       (dout),
      .oe_n       (oe_n),
      .kbdjoy_in  (kbdjoy_in),
      .db9joy_in  (db9joy_in),
      .kbdcol_in  (kbdcol_in),
      .kbdcol_out (kbdcol_out)
   );

   // 20 ns period
   always #10 clk = ~clk;

   ////////////////////
   // Bus tasks
   ////////////////////

   // Joystick and column inputs for the next operation
   task automatic apply_inputs(input logic [4:0] kj, input logic [4:0] dj, input logic [4:0] kc);
      @(posedge clk);
      kbdjoy_in <= kj;
      db9joy_in <= dj;
      kbdcol_in <= kc;
   endtask

   // One I/O cycle, held 3 clocks, sampled before release
   task automatic bus_cycle(
      input  logic        is_rd,
      input  logic [15:0] addr,
      input  logic [7:0]  data,
      output logic [7:0]  rdata,
      output logic        rd_oe_n
   );
      int n;
      @(posedge clk);
      a <= addr;
      din <= data;
      iorq_n <= 1'b0;
      rd_n <= !is_rd;
      wr_n <= is_rd;
      // Start seen at the first edge, strobe done by the second
      repeat (2) @(posedge clk);
      @(negedge clk);
      rdata = dout;
      rd_oe_n = oe_n;
      @(posedge clk);
      iorq_n <= 1'b1;
      rd_n <= 1'b1;
      wr_n <= 1'b1;
      // Bus must be released once iorq_n is high
      n = 0;
      @(negedge clk);
      while (oe_n !== 1'b1 && n < release_timeout) begin
         @(negedge clk);
         n++;
      end
      if (oe_n !== 1'b1) begin
         $display("Timeout at %0t: oe_n stayed low after the cycle to port %h ended",
                  $time, addr);
         other_errs++;
      end
   endtask

   // Column path is combinational, rows come from the address
   task automatic col_check(input logic [15:0] addr, input logic [4:0] expected);
      @(posedge clk);
      a <= addr;
      @(negedge clk);
      checks++;
      if (kbdcol_out !== expected) begin
         $display("CHECK FAILED at %0t: kbdcol_out %h with address %h, expected %h",
                  $time, kbdcol_out, addr, expected);
         check_errs++;
      end
   endtask

   ////////////////////
   // One pattern line
   ////////////////////

   task automatic run_op(
      input string       op,
      input logic [15:0] port,
      input logic [7:0]  data,
      input logic [7:0]  expected
   );
      logic [7:0] rdata;
      logic       rd_oe_n;
      if (op == "W") begin
         bus_cycle(1'b0, port, data, rdata, rd_oe_n);
      end else if (op == "R") begin
         bus_cycle(1'b1, port, data, rdata, rd_oe_n);
         checks++;
         if (rd_oe_n !== 1'b0) begin
            $display("CHECK FAILED at %0t: read of port %h left oe_n high, expected %h",
                     $time, port, expected);
            check_errs++;
         end else if (rdata !== expected) begin
            $display("CHECK FAILED at %0t: read of port %h gave %h, expected %h",
                     $time, port, rdata, expected);
            check_errs++;
         end
      end else if (op == "N") begin
         bus_cycle(1'b1, port, data, rdata, rd_oe_n);
         checks++;
         // Nobody may answer this read
         if (rd_oe_n !== 1'b1) begin
            $display("CHECK FAILED at %0t: read of port %h drove oe_n low with %h",
                     $time, port, rdata);
            check_errs++;
         end
      end else if (op == "K") begin
         col_check(port, expected[4:0]);
      end else begin
         $display("Unknown operation %s in the pattern file", op);
         other_errs++;
      end
   endtask

   ////////////////////
   // Main sequence
   ////////////////////

   initial begin
      int          fd;
      int          n;
      int          lines;
      int          i;
      string       line;
      string       op;
      logic [15:0] f_port;
      logic [7:0]  f_data;
      logic [4:0]  f_kj;
      logic [4:0]  f_dj;
      logic [4:0]  f_kc;
      logic [7:0]  f_exp;
      clk = 1'b0;
      rst = 1'b1;
      a = 16'h0000;
      iorq_n = 1'b1;
      rd_n = 1'b1;
      wr_n = 1'b1;
      din = 8'h00;
      kbdjoy_in = 5'h00;
      db9joy_in = 5'h00;
      kbdcol_in = 5'h1F;
      checks = 0;
      check_errs = 0;
      other_errs = 0;
      // Reset for 5 clocks
      for (i = 0; i < 5; i++) begin
         @(posedge clk);
      end
      rst <= 1'b0;
      fd = $fopen("verif/zxuno_io_patterns.txt", "r");
      if (fd == 0) begin
         $display("Could not open the pattern file verif/zxuno_io_patterns.txt");
         other_errs++;
      end else begin
         lines = 0;
         while (!$feof(fd) && lines < max_lines) begin
            line = "";
            n = $fgets(line, fd);
            lines++;
            // Skip comments and blank lines
            if (n > 1 && line.getc(0) != "#" && line.getc(0) != "\n") begin
               n = $sscanf(line, "%s %h %h %h %h %h %h",
                           op, f_port, f_data, f_kj, f_dj, f_kc, f_exp);
               if (n != 7) begin
                  $display("Pattern line %0d does not have seven fields", lines);
                  other_errs++;
               end else begin
                  apply_inputs(f_kj, f_dj, f_kc);
                  run_op(op, f_port, f_data, f_exp);
               end
            end
         end
         $fclose(fd);
      end
      if (checks == 0) begin
         $display("No checks were run");
         other_errs++;
      end
      $display("Checks %0d, value errors %0d, other errors %0d",
               checks, check_errs, other_errs);
      if (check_errs == 0 && other_errs == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- verilog/zxuno_io.sv
`timescale 1ns/1ps
`default_nettype none

module zxuno_io (
   input  logic        clk,
   input  logic        rst,
   input  logic [15:0] a,
   input  logic        iorq_n,
   input  logic        rd_n,
   input  logic        wr_n,
   input  logic [7:0]  din,
   output logic [7:0]  dout,
   output logic        oe_n,
   input  logic [4:0]  kbdjoy_in,
   input  logic [4:0]  db9joy_in,
   input  logic [4:0]  kbdcol_in,
   output logic [4:0]  kbdcol_out
);
   import zxuno_pkg::*;

   // Register bank bus
   zxuno_reg_if regs_if ();

   // Per block read data
   logic [7:0] regs_dout;
   logic       regs_oe_n;
   logic [7:0] coreid_dout;
   logic       coreid_oe_n;
   logic [7:0] joy_dout;
   logic       joy_oe_n;

   ////////////////////
   // Blocks
   ////////////////////

   zxuno_regs regs0 (
      .clk    (clk),
      .rst    (rst),
      .a      (a),
      .iorq_n (iorq_n),
      .rd_n   (rd_n),
      .wr_n   (wr_n),
      .din    (din),
      .dout   (regs_dout),
      .oe_n   (regs_oe_n),
      .regs   (regs_if.master)
   );

   core_id core_id0 (
      .clk  (clk),
      .rst  (rst),
      .regs (regs_if.periph),
      .dout (coreid_dout),
      .oe_n (coreid_oe_n)
   );

   joystick_protocols joy0 (
      .clk        (clk),
      .rst        (rst),
      .a          (a),
      .iorq_n     (iorq_n),
      .rd_n       (rd_n),
      .din        (din),
      .regs       (regs_if.periph),
      .kbdjoy_in  (kbdjoy_in),
      .db9joy_in  (db9joy_in),
      .kbdcol_in  (kbdcol_in),
      .kbdcol_out (kbdcol_out),
      .dout       (joy_dout),
      .oe_n       (joy_oe_n)
   );

   ////////////////////
   // Read data mux
   ////////////////////

   logic data_rd;

   // Core ID only drives the bus during a data port read
   assign data_rd = !iorq_n && !rd_n && (a == zxuno_data_port);

   // Fixed priority, FF with the bus released when nobody answers
   always_comb begin
      if (!regs_oe_n) begin
         dout = regs_dout;
         oe_n = 1'b0;
      end else if (!coreid_oe_n && data_rd) begin
         dout = coreid_dout;
         oe_n = 1'b0;
      end else if (!joy_oe_n) begin
         dout = joy_dout;
         oe_n = 1'b0;
      end else begin
         dout = 8'hFF;
         oe_n = 1'b1;
      end
   end

endmodule

`default_nettype wire

//--- verilog/joystick_protocols.sv
`timescale 1ns/1ps
`default_nettype none

module joystick_protocols (
   input  logic            clk,
   input  logic            rst,
   input  logic [15:0]     a,
   input  logic            iorq_n,
   input  logic            rd_n,
   input  logic [7:0]      din,
   zxuno_reg_if.periph     regs,
   input  zxuno_pkg::joy_bit kbdjoy_in,
   input  zxuno_pkg::joy_bit db9joy_in,
   input  logic [4:0]      kbdcol_in,
   output logic [4:0]      kbdcol_out,
   output logic [7:0]      dout,
   output logic            oe_n
);
   import zxuno_pkg::*;

   ////////////////////
   // Config register
   ////////////////////

   joy_conf_u conf;

   always_ff @(posedge clk) begin
      if (rst) begin
         // All sources off
         conf.raw <= 8'h00;
      end else if (regs.regwr && (regs.regnum == reg_joyconf)) begin
         conf.raw <= din;
      end
   end

   ////////////////////
   // Kempston and Fuller
   ////////////////////

   logic   kemp_en;
   logic   fuller_en;
   joy_bit kemp_bits;
   joy_bit fuller_bits;

   // Port answers only while some source uses it
   assign kemp_en = (conf.f.kbd == joy_kempston) || (conf.f.db9 == joy_kempston);
   assign fuller_en = (conf.f.kbd == joy_fuller) || (conf.f.db9 == joy_fuller);

   // Both sources on one protocol are ORed
   assign kemp_bits = ((conf.f.kbd == joy_kempston) ? kbdjoy_in : 5'b00000)
                    | ((conf.f.db9 == joy_kempston) ? db9joy_in : 5'b00000);
   assign fuller_bits = ((conf.f.kbd == joy_fuller) ? kbdjoy_in : 5'b00000)
                      | ((conf.f.db9 == joy_fuller) ? db9joy_in : 5'b00000);

   ////////////////////
   // CPU reads
   ////////////////////

   logic io_rd;
   logic conf_rd;
   logic kemp_rd;
   logic fuller_rd;

   assign io_rd = !iorq_n && !rd_n;
   assign conf_rd = io_rd && (a == zxuno_data_port) && (regs.regnum == reg_joyconf);
   // Low byte decode only
   assign kemp_rd = io_rd && (a[7:0] == kempston_port) && kemp_en;
   assign fuller_rd = io_rd && (a[7:0] == fuller_port) && fuller_en;

   always_comb begin
      if (conf_rd) begin
         dout = conf.raw;
      end else if (kemp_rd) begin
         // Bits 000 fire up down left right active high
         dout = {3'b000, kemp_bits};
      end else if (fuller_rd) begin
         // Bits fire 111 right left down up active low
         dout = {~fuller_bits[jb_fire], 3'b111, ~fuller_bits[jb_right],
                 ~fuller_bits[jb_left], ~fuller_bits[jb_down], ~fuller_bits[jb_up]};
      end else begin
         dout = 8'hFF;
      end
   end

   assign oe_n = !(conf_rd || kemp_rd || fuller_rd);

   ////////////////////
   // Keyboard columns
   ////////////////////

   // Active high pressed columns for one source
   function automatic logic [4:0] col_mask(
      input logic [2:0] proto,
      input joy_bit     j,
      input logic       row11,
      input logic       row12
   );
      logic [4:0] m;
      m = 5'b00000;
      case (proto)
         joy_sinclair1: begin
            // Keys 6 to 0 on row A12
            if (row12) begin
               m = {j[jb_left], j[jb_right], j[jb_down], j[jb_up], j[jb_fire]};
            end
         end
         joy_sinclair2: begin
            // Keys 1 to 5 on row A11
            if (row11) begin
               m = {j[jb_fire], j[jb_up], j[jb_down], j[jb_right], j[jb_left]};
            end
         end
         joy_cursor: begin
            // Left is key 5 on row A11
            if (row11) begin
               m[4] = j[jb_left];
            end
            // Keys 6 7 8 and 0 on row A12
            if (row12) begin
               m = m | {j[jb_down], j[jb_up], j[jb_right], 1'b0, j[jb_fire]};
            end
         end
         default: begin
            // No keys for the other protocols
            m = 5'b00000;
         end
      endcase
      return m;
   endfunction

   logic       row11_sel;
   logic       row12_sel;
   logic [4:0] key_mask;

   // Row is scanned when its address line is low
   assign row11_sel = !a[11];
   assign row12_sel = !a[12];

   assign key_mask = col_mask(conf.f.kbd, kbdjoy_in, row11_sel, row12_sel)
                   | col_mask(conf.f.db9, db9joy_in, row11_sel, row12_sel);

   // Active low columns
   // A pressed key pulls its column down
   assign kbdcol_out = kbdcol_in & ~key_mask;

endmodule

`default_nettype wire

//--- verilog/core_id.sv
`timescale 1ns/1ps
`default_nettype none

module core_id (
   input  logic        clk,
   input  logic        rst,
   zxuno_reg_if.periph regs,
   output logic [7:0]  dout,
   output logic        oe_n
);
   import zxuno_pkg::*;

   // Next character to hand out, coreid_len once the string is done
   logic [coreid_idx_w-1:0] idx;
   // Character returned by the read in progress
   logic [7:0] rd_char;
   logic [7:0] cur_char;
   logic       id_sel;
   logic       at_end;

   assign id_sel = (regs.regnum == reg_coreid);
   assign at_end = (idx == coreid_idx_w'(coreid_len));

   // Character at idx, zero past the end
   always_comb begin
      if (at_end) begin
         cur_char = 8'h00;
      end else begin
         cur_char = coreid_text[8*(coreid_len-1-int'(idx)) +: 8];
      end
   end

   ////////////////////
   // Index
   ////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         idx <= '0;
      end else if (regs.regnum_changed) begin
         // Any reselect restarts the string
         idx <= '0;
      end else if (regs.regrd && id_sel && !at_end) begin
         idx <= idx + 1'b1;
      end
   end

   // Hold the character after idx has moved on
   always_ff @(posedge clk) begin
      if (regs.regrd && id_sel) begin
         rd_char <= cur_char;
      end
   end

   // During the strobe idx still points at this read's character
   assign dout = regs.regrd ? cur_char : rd_char;
   // ID register selected, top level qualifies with the data port read
   assign oe_n = !id_sel;

endmodule

`default_nettype wire

//--- verilog/zxuno_regs.sv
`timescale 1ns/1ps
`default_nettype none

module zxuno_regs (
   input  logic              clk,
   input  logic              rst,
   input  logic [15:0]       a,
   input  logic              iorq_n,
   input  logic              rd_n,
   input  logic              wr_n,
   input  logic [7:0]        din,
   output logic [7:0]        dout,
   output logic              oe_n,
   zxuno_reg_if.master       regs
);
   import zxuno_pkg::*;

   ////////////////////
   // Port decode
   ////////////////////

   logic addr_sel;
   logic data_sel;
   logic addr_rd;
   logic addr_wr;
   logic data_rd;
   logic data_wr;

   assign addr_sel = !iorq_n && (a == zxuno_addr_port);
   assign data_sel = !iorq_n && (a == zxuno_data_port);

   assign addr_rd = addr_sel && !rd_n;
   assign addr_wr = addr_sel && !wr_n;
   assign data_rd = data_sel && !rd_n;
   assign data_wr = data_sel && !wr_n;

   ////////////////////
   // Cycle start detect
   ////////////////////

   // Access terms as seen at the previous edge
   logic addr_wr_q;
   logic data_rd_q;
   logic data_wr_q;

   logic addr_wr_start;
   logic data_rd_start;
   logic data_wr_start;

   // Seen now, not seen at the edge before
   assign addr_wr_start = addr_wr && !addr_wr_q;
   assign data_rd_start = data_rd && !data_rd_q;
   assign data_wr_start = data_wr && !data_wr_q;

   always_ff @(posedge clk) begin
      if (rst) begin
         addr_wr_q <= 1'b0;
         data_rd_q <= 1'b0;
         data_wr_q <= 1'b0;
         regs.regnum <= 8'h00;
         regs.regrd <= 1'b0;
         regs.regwr <= 1'b0;
         regs.regnum_changed <= 1'b0;
      end else begin
         addr_wr_q <= addr_wr;
         data_rd_q <= data_rd;
         data_wr_q <= data_wr;
         // Strobes last one clk each
         regs.regrd <= data_rd_start;
         regs.regwr <= data_wr_start;
         regs.regnum_changed <= addr_wr_start;
         // New register number, taken once per write cycle
         if (addr_wr_start) begin
            regs.regnum <= din;
         end
      end
   end

   // Address port readback, valid for the whole read cycle
   assign dout = regs.regnum;
   assign oe_n = !addr_rd;

endmodule

`default_nettype wire

//--- verilog/zxuno_reg_if.sv
`timescale 1ns/1ps
`default_nettype none

// Register bank bus, from the register ports to the peripherals
interface zxuno_reg_if;

   // Currently selected register
   logic [7:0] regnum;

   // One clk wide, at the start of a data port cycle
   logic regrd;
   logic regwr;

   // One clk wide, on every write to the address port
   logic regnum_changed;

   // Register port side
   modport master (
      output regnum,
      output regrd,
      output regwr,
      output regnum_changed
   );

   // Peripheral side
   modport periph (
      input regnum,
      input regrd,
      input regwr,
      input regnum_changed
   );

endinterface

`default_nettype wire

//--- verilog/zxuno_pkg.sv
`default_nettype none

package zxuno_pkg;

   ////////////////////
   // Bus ports
   ////////////////////

   // Register bank ports, full 16-bit decode
   localparam logic [15:0] zxuno_addr_port = 16'hFC3B;
   localparam logic [15:0] zxuno_data_port = 16'hFD3B;

   // Joystick ports, only the low address byte is decoded
   localparam logic [7:0] kempston_port = 8'h1F;
   localparam logic [7:0] fuller_port = 8'h7F;

   ////////////////////
   // Register numbers
   ////////////////////

   localparam logic [7:0] reg_joyconf = 8'h06;
   localparam logic [7:0] reg_coreid = 8'hFF;

   ////////////////////
   // Joystick
   ////////////////////

   // Protocol codes, one per source in the config byte
   localparam logic [2:0] joy_off = 3'd0;
   localparam logic [2:0] joy_kempston = 3'd1;
   localparam logic [2:0] joy_sinclair1 = 3'd2;
   localparam logic [2:0] joy_sinclair2 = 3'd3;
   localparam logic [2:0] joy_cursor = 3'd4;
   localparam logic [2:0] joy_fuller = 3'd5;

   // Direction vector, fire up down left right, 1 = pressed
   typedef logic [4:0] joy_bit;

   // Bit positions inside joy_bit
   localparam int jb_fire = 4;
   localparam int jb_up = 3;
   localparam int jb_down = 2;
   localparam int jb_left = 1;
   localparam int jb_right = 0;

   // Config byte, raw for readback, fields for decode
   typedef union packed {
      logic [7:0] raw;
      struct packed {
         logic       rsv7;
         logic [2:0] db9;
         logic       rsv3;
         logic [2:0] kbd;
      } f;
   } joy_conf_u;

   ////////////////////
   // Core ID
   ////////////////////

   localparam int coreid_len = 8;
   // Index runs 0..coreid_len, last value means past the end
   localparam int coreid_idx_w = $clog2(coreid_len + 1);
   // First character sits in the top byte
   localparam logic [8*coreid_len-1:0] coreid_text = "ZXIO2025";

endpackage

`default_nettype wire
